// ==== logic/board_ctrl_pkg.sv ====
package board_ctrl_pkg;

  // bus and register widths
  typedef logic [4:0] epb_addr_t;   // [4:3] slave, [2:0] offset
  typedef logic [7:0] bus_data_t;
  typedef logic [2:0] reg_offset_t;
  typedef logic [1:0] slave_id_t;

  // epb bridge sequencing
  typedef enum logic [2:0] {
    IDLE,
    REQ,
    WAIT_ACK,
    HOLD,
    RELEASE
  } bridge_state_t;

  // address map, ids 2 and 3 are unmapped
  localparam slave_id_t SLAVE_MISC  = 2'd0;
  localparam slave_id_t SLAVE_RESET = 2'd1;

  // misc_regs offsets
  localparam reg_offset_t MISC_SYS_CONFIG = 3'd0;
  localparam reg_offset_t MISC_DIPS       = 3'd1;
  localparam reg_offset_t MISC_LED        = 3'd2;
  localparam reg_offset_t MISC_WP         = 3'd3;
  localparam reg_offset_t MISC_SCRATCH    = 3'd4;
  localparam reg_offset_t MISC_STATUS     = 3'd5;

  // reset_ctrl offsets
  localparam reg_offset_t RST_CONTROL = 3'd0;

  // read value returned for unmapped slaves
  localparam bus_data_t UNMAPPED_DATA = 8'h00;

endpackage

// ==== logic/epb_bridge.sv ====
`timescale 1ns/100ps

module epb_bridge (
  input  logic                    clk_master,
  input  logic                    reset_mon,
  input  logic                    epb_cs_n_i,
  input  logic                    epb_we_n_i,
  input  board_ctrl_pkg::epb_addr_t epb_addr_i,
  input  board_ctrl_pkg::bus_data_t epb_wdata_i,
  output board_ctrl_pkg::bus_data_t epb_rdata_o,
  output logic                    epb_rdy_o,
  output logic                    bus_req_o,
  output logic                    bus_we_o,
  output board_ctrl_pkg::epb_addr_t bus_addr_o,
  output board_ctrl_pkg::bus_data_t bus_wdata_o,
  input  logic                    bus_ack_i,
  input  board_ctrl_pkg::bus_data_t bus_rdata_i
);

  import board_ctrl_pkg::*;

  bridge_state_t state;

  // capture of the host cycle, held for the whole transaction
  always_ff @(posedge clk_master) begin
    if (state == IDLE && !epb_cs_n_i) begin
      bus_addr_o  <= epb_addr_i;
      bus_we_o    <= !epb_we_n_i;  // epb write strobe is active low
      bus_wdata_o <= epb_wdata_i;
    end
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      state     <= IDLE;
      bus_req_o <= 1'b0;
      epb_rdy_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (!epb_cs_n_i) state <= REQ;
        end
        REQ: begin
          bus_req_o <= 1'b1;
          state     <= WAIT_ACK;
        end
        WAIT_ACK: begin
          if (bus_ack_i) begin
            epb_rdy_o <= 1'b1;
            state     <= HOLD;
          end
        end
        HOLD: begin
          // host still owns the cycle, keep everything up
          if (epb_cs_n_i) state <= RELEASE;
        end
        RELEASE: begin
          bus_req_o <= 1'b0;
          if (!bus_req_o && !bus_ack_i) begin  // internal handshake fully back to zero
            epb_rdy_o <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // read data goes out together with ready
  always_ff @(posedge clk_master) begin
    if (state == WAIT_ACK && bus_ack_i) epb_rdata_o <= bus_rdata_i;
  end

  req_held_until_ack: assert property (
    @(posedge clk_master) disable iff (reset_mon)
    $fell(bus_req_o) |-> $past(bus_ack_i)
  );

  rdy_only_in_cycle: assert property (
    @(posedge clk_master) disable iff (reset_mon)
    $rose(epb_rdy_o) |-> !$past(epb_cs_n_i)
  );

endmodule

// ==== logic/bus_decode.sv ====
`timescale 1ns/100ps

module bus_decode (
  input  logic                      clk_master,
  input  logic                      reset_mon,
  input  logic                      bus_req_i,
  input  board_ctrl_pkg::epb_addr_t   bus_addr_i,
  output logic                      misc_req_o,
  output logic                      rst_req_o,
  output logic                      unmapped_req_o,
  output board_ctrl_pkg::reg_offset_t offset_o,
  output board_ctrl_pkg::slave_id_t   sel_slave_o
);

  import board_ctrl_pkg::*;

  slave_id_t addr_slave;
  logic      active;

  assign addr_slave = bus_addr_i[4:3];
  assign active     = misc_req_o | rst_req_o | unmapped_req_o;  // a request is being served

  // select and offset are latched once and held until the request drops
  always_ff @(posedge clk_master) begin
    if (bus_req_i && !active) begin
      sel_slave_o <= addr_slave;
      offset_o    <= bus_addr_i[2:0];
    end
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      misc_req_o     <= 1'b0;
      rst_req_o      <= 1'b0;
      unmapped_req_o <= 1'b0;
    end else if (bus_req_i && !active) begin
      misc_req_o     <= (addr_slave == SLAVE_MISC);
      rst_req_o      <= (addr_slave == SLAVE_RESET);
      unmapped_req_o <= (addr_slave != SLAVE_MISC) && (addr_slave != SLAVE_RESET);
    end else if (!bus_req_i) begin
      misc_req_o     <= 1'b0;
      rst_req_o      <= 1'b0;
      unmapped_req_o <= 1'b0;
    end
  end

  // a new request waits until the previous target has dropped
  one_request_at_a_time: assert property (
    @(posedge clk_master) disable iff (reset_mon)
    $rose(bus_req_i) |-> !active
  );

endmodule

// ==== logic/misc_regs.sv ====
`timescale 1ns/100ps

module misc_regs (
  input  logic                      clk_master,
  input  logic                      reset_mon,
  input  logic                      req_i,
  input  logic                      we_i,
  input  board_ctrl_pkg::reg_offset_t offset_i,
  input  board_ctrl_pkg::bus_data_t   wdata_i,
  output logic                      ack_o,
  output board_ctrl_pkg::bus_data_t   rdata_o,
  input  board_ctrl_pkg::bus_data_t   sys_config_i,
  input  logic [3:0]                user_dip_i,
  input  logic [3:0]                config_dip_i,
  input  logic                      flash_busy_n_i,
  input  logic                      ppc_syserr_i,
  output logic [1:0]                user_led_n_o,
  output logic                      eeprom_wp_o,
  output logic                      flash_wp_n_o
);

  import board_ctrl_pkg::*;

  logic [1:0] led_q;
  logic [1:0] wp_q;      // bit 0 eeprom, bit 1 flash
  bus_data_t  scratch_q;
  bus_data_t  rd_val;
  logic       access;

  // first cycle of a request
  assign access = req_i && !ack_o;

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      ack_o <= 1'b0;
    end else if (access) begin
      ack_o <= 1'b1;
    end else if (!req_i) begin
      ack_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      led_q     <= 2'b00;
      wp_q      <= 2'b00;
      scratch_q <= '0;
    end else if (access && we_i) begin
      case (offset_i)
        MISC_LED:     led_q     <= wdata_i[1:0];
        MISC_WP:      wp_q      <= wdata_i[1:0];
        MISC_SCRATCH: scratch_q <= wdata_i;
        default: ;    // read-only or empty offsets ignore writes
      endcase
    end
  end

  always_comb begin
    case (offset_i)
      MISC_SYS_CONFIG: rd_val = sys_config_i;
      MISC_DIPS:       rd_val = {user_dip_i, config_dip_i};
      MISC_LED:        rd_val = {6'b0, led_q};
      MISC_WP:         rd_val = {6'b0, wp_q};
      MISC_SCRATCH:    rd_val = scratch_q;
      MISC_STATUS:     rd_val = {6'b0, !flash_busy_n_i, ppc_syserr_i};
      default:         rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_master) begin
    if (access) rdata_o <= rd_val;  // sampled with the ack
  end

  assign user_led_n_o = ~led_q;                  // leds are active low on the board
  assign eeprom_wp_o  = user_dip_i[3] | wp_q[0]; // dip switch can force protect
  assign flash_wp_n_o = !wp_q[1];

endmodule

// ==== logic/reset_ctrl.sv ====
`timescale 1ns/100ps

module reset_ctrl (
  input  logic                      clk_master,
  input  logic                      reset_mon,
  input  logic                      reset_por_n_i,
  input  logic                      reset_debug_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  board_ctrl_pkg::reg_offset_t offset_i,
  input  board_ctrl_pkg::bus_data_t   wdata_i,
  output logic                      ack_o,
  output board_ctrl_pkg::bus_data_t   rdata_o,
  output logic                      ppc_reset_n_o,
  output logic                      ppc_ddr2_reset_n_o,
  output logic                      geth_reset_n_o,
  output logic                      por_force_n_o
);

  import board_ctrl_pkg::*;

  logic sys_reset;
  logic por_force_q;  // sticky, only a power-on reset clears it
  logic geth_rst_q;
  logic access;

  assign sys_reset = reset_mon || !reset_por_n_i;
  assign access    = req_i && !ack_o;

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      ack_o <= 1'b0;
    end else if (access) begin
      ack_o <= 1'b1;
    end else if (!req_i) begin
      ack_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      por_force_q <= 1'b0;
      geth_rst_q  <= 1'b0;
    end else if (access && we_i && offset_i == RST_CONTROL) begin
      por_force_q <= por_force_q | wdata_i[0];  // writing 0 has no effect
      geth_rst_q  <= wdata_i[1];
    end
  end

  always_ff @(posedge clk_master) begin
    if (access) rdata_o <= (offset_i == RST_CONTROL) ? {6'b0, geth_rst_q, por_force_q} : '0;
  end

  assign ppc_ddr2_reset_n_o = !sys_reset;
  assign ppc_reset_n_o      = reset_debug_n_i && !sys_reset;
  assign geth_reset_n_o     = !(sys_reset || geth_rst_q);
  assign por_force_n_o      = !por_force_q;

endmodule

// ==== logic/bus_return.sv ====
`timescale 1ns/100ps

module bus_return (
  input  logic                    clk_master,
  input  logic                    reset_mon,
  input  logic                    misc_ack_i,
  input  board_ctrl_pkg::bus_data_t misc_rdata_i,
  input  logic                    rst_ack_i,
  input  board_ctrl_pkg::bus_data_t rst_rdata_i,
  input  logic                    unmapped_req_i,
  input  board_ctrl_pkg::slave_id_t sel_slave_i,
  output logic                    bus_ack_o,
  output board_ctrl_pkg::bus_data_t bus_rdata_o
);

  import board_ctrl_pkg::*;

  logic      unmapped_ack_q;  // stands in for a slave on unmapped ids
  bus_data_t rdata_sel;

  always_comb begin
    case (sel_slave_i)
      SLAVE_MISC:  rdata_sel = misc_rdata_i;
      SLAVE_RESET: rdata_sel = rst_rdata_i;
      default:     rdata_sel = UNMAPPED_DATA;
    endcase
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      unmapped_ack_q <= 1'b0;
      bus_ack_o      <= 1'b0;
    end else begin
      unmapped_ack_q <= unmapped_req_i;
      bus_ack_o      <= misc_ack_i | rst_ack_i | unmapped_ack_q;
    end
  end

  always_ff @(posedge clk_master) begin
    bus_rdata_o <= rdata_sel;
  end

  // the acking source must be the slave that decode selected
  ack_from_selected: assert property (
    @(posedge clk_master) disable iff (reset_mon)
    $rose(bus_ack_o) |-> $past((misc_ack_i && sel_slave_i == SLAVE_MISC) ||
                               (rst_ack_i && sel_slave_i == SLAVE_RESET) ||
                               (unmapped_ack_q && sel_slave_i[1]))
  );

endmodule

// ==== logic/board_ctrl_top.sv ====
`timescale 1ns/100ps

module board_ctrl_top (
  input  logic                    clk_master,
  input  logic                    reset_mon,
  // host epb side
  input  logic                    epb_cs_n_i,
  input  logic                    epb_we_n_i,
  input  board_ctrl_pkg::epb_addr_t epb_addr_i,
  input  board_ctrl_pkg::bus_data_t epb_wdata_i,
  output board_ctrl_pkg::bus_data_t epb_rdata_o,
  output logic                    epb_rdy_o,
  // board switches, status and protects
  input  board_ctrl_pkg::bus_data_t sys_config_i,
  input  logic [3:0]              user_dip_i,
  input  logic [3:0]              config_dip_i,
  input  logic                    flash_busy_n_i,
  input  logic                    ppc_syserr_i,
  output logic [1:0]              user_led_n_o,
  output logic                    eeprom_wp_o,
  output logic                    flash_wp_n_o,
  // resets
  input  logic                    reset_por_n_i,
  input  logic                    reset_debug_n_i,
  output logic                    ppc_reset_n_o,
  output logic                    ppc_ddr2_reset_n_o,
  output logic                    geth_reset_n_o,
  output logic                    por_force_n_o
);

  import board_ctrl_pkg::*;

  logic        bus_req, bus_we, bus_ack;
  epb_addr_t   bus_addr;
  bus_data_t   bus_wdata, bus_rdata;
  logic        misc_req, rst_req, unmapped_req;
  reg_offset_t offset;
  slave_id_t   sel_slave;
  logic        misc_ack, rst_ack;
  bus_data_t   misc_rdata, rst_rdata;

  epb_bridge u_epb_bridge (
    .clk_master, .reset_mon,
    .epb_cs_n_i, .epb_we_n_i, .epb_addr_i, .epb_wdata_i, .epb_rdata_o, .epb_rdy_o,
    .bus_req_o(bus_req), .bus_we_o(bus_we), .bus_addr_o(bus_addr),
    .bus_wdata_o(bus_wdata), .bus_ack_i(bus_ack), .bus_rdata_i(bus_rdata)
  );

  bus_decode u_bus_decode (
    .clk_master, .reset_mon,
    .bus_req_i(bus_req), .bus_addr_i(bus_addr),
    .misc_req_o(misc_req), .rst_req_o(rst_req), .unmapped_req_o(unmapped_req),
    .offset_o(offset), .sel_slave_o(sel_slave)
  );

  misc_regs u_misc_regs (
    .clk_master, .reset_mon,
    .req_i(misc_req), .we_i(bus_we), .offset_i(offset), .wdata_i(bus_wdata),
    .ack_o(misc_ack), .rdata_o(misc_rdata),
    .sys_config_i, .user_dip_i, .config_dip_i, .flash_busy_n_i, .ppc_syserr_i,
    .user_led_n_o, .eeprom_wp_o, .flash_wp_n_o
  );

  reset_ctrl u_reset_ctrl (
    .clk_master, .reset_mon, .reset_por_n_i, .reset_debug_n_i,
    .req_i(rst_req), .we_i(bus_we), .offset_i(offset), .wdata_i(bus_wdata),
    .ack_o(rst_ack), .rdata_o(rst_rdata),
    .ppc_reset_n_o, .ppc_ddr2_reset_n_o, .geth_reset_n_o, .por_force_n_o
  );

  bus_return u_bus_return (
    .clk_master, .reset_mon,
    .misc_ack_i(misc_ack), .misc_rdata_i(misc_rdata),
    .rst_ack_i(rst_ack), .rst_rdata_i(rst_rdata),
    .unmapped_req_i(unmapped_req), .sel_slave_i(sel_slave),
    .bus_ack_o(bus_ack), .bus_rdata_o(bus_rdata)
  );

endmodule

// ==== verification/board_ctrl_checker.sv ====
`timescale 1ns/100ps

module board_ctrl_checker (
  input  logic                      clk_master,
  input  logic                      reset_mon,
  input  logic                      epb_cs_n_i,
  input  logic                      epb_we_n_i,
  input  board_ctrl_pkg::epb_addr_t epb_addr_i,
  input  board_ctrl_pkg::bus_data_t epb_wdata_i,
  input  board_ctrl_pkg::bus_data_t epb_rdata_i,
  input  logic                      epb_rdy_i,
  input  board_ctrl_pkg::bus_data_t sys_config_i,
  input  logic [3:0]                user_dip_i,
  input  logic [3:0]                config_dip_i,
  input  logic                      flash_busy_n_i,
  input  logic                      ppc_syserr_i,
  input  logic                      reset_por_n_i,
  input  logic                      reset_debug_n_i,
  input  logic [1:0]                user_led_n_i,
  input  logic                      eeprom_wp_i,
  input  logic                      flash_wp_n_i,
  input  logic                      ppc_reset_n_i,
  input  logic                      ppc_ddr2_reset_n_i,
  input  logic                      geth_reset_n_i,
  input  logic                      por_force_n_i,
  output int                        error_count_o,
  output int                        check_count_o
);

  import board_ctrl_pkg::*;

  // shadow of the writable registers
  logic [1:0] led_s = '0;
  logic [1:0] wp_s = '0;       // bit 0 eeprom, bit 1 flash
  bus_data_t  scratch_s = '0;
  logic       por_s = 1'b0;
  logic       geth_s = 1'b0;

  // host cycle being tracked
  logic       txn_open = 1'b0;
  logic       rdy_seen = 1'b0;
  logic       t_we;
  epb_addr_t  t_addr;
  bus_data_t  t_wdata;
  logic       rdy_prev = 1'b0;
  logic       cs_n_prev = 1'b1;
  int         errors = 0;
  int         checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  // read value of one address, from the register map rules
  function automatic bus_data_t expected_read(epb_addr_t addr);
    bus_data_t val;
    val = UNMAPPED_DATA;
    if (addr[4:3] == SLAVE_MISC) begin
      case (addr[2:0])
        MISC_SYS_CONFIG: val = sys_config_i;
        MISC_DIPS:       val = {user_dip_i, config_dip_i};
        MISC_LED:        val = {6'b0, led_s};
        MISC_WP:         val = {6'b0, wp_s};
        MISC_SCRATCH:    val = scratch_s;
        MISC_STATUS:     val = {6'b0, !flash_busy_n_i, ppc_syserr_i};
        default:         val = 8'h00;
      endcase
    end else if (addr[4:3] == SLAVE_RESET && addr[2:0] == RST_CONTROL) begin
      val = {6'b0, geth_s, por_s};
    end
    return val;
  endfunction

  // {led_n[1:0], eeprom_wp, flash_wp_n, ppc_rst_n, ddr2_rst_n, geth_rst_n, por_force_n}
  function automatic logic [7:0] expected_pins();
    logic sys_rst;
    sys_rst = reset_mon || !reset_por_n_i;
    return {~led_s, user_dip_i[3] | wp_s[0], !wp_s[1], reset_debug_n_i && !sys_rst,
            !sys_rst, !(sys_rst || geth_s), !por_s};
  endfunction

  task automatic compare_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_fault(input string what);
    errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  task automatic apply_write(input epb_addr_t addr, input bus_data_t data);
    if (addr[4:3] == SLAVE_MISC) begin
      case (addr[2:0])
        MISC_LED:     led_s = data[1:0];
        MISC_WP:      wp_s = data[1:0];
        MISC_SCRATCH: scratch_s = data;
        default: ;    // read-only offsets
      endcase
    end else if (addr[4:3] == SLAVE_RESET && addr[2:0] == RST_CONTROL) begin
      por_s  = por_s | data[0];  // only set by software
      geth_s = data[1];
    end
  endtask

  task automatic check_pins();
    logic [7:0] exp;
    exp = expected_pins();
    compare_value("user_led_n_o", {6'b0, user_led_n_i}, {6'b0, exp[7:6]});
    compare_value("eeprom_wp_o", {7'b0, eeprom_wp_i}, {7'b0, exp[5]});
    compare_value("flash_wp_n_o", {7'b0, flash_wp_n_i}, {7'b0, exp[4]});
    compare_value("ppc_reset_n_o", {7'b0, ppc_reset_n_i}, {7'b0, exp[3]});
    compare_value("ppc_ddr2_reset_n_o", {7'b0, ppc_ddr2_reset_n_i}, {7'b0, exp[2]});
    compare_value("geth_reset_n_o", {7'b0, geth_reset_n_i}, {7'b0, exp[1]});
    compare_value("por_force_n_o", {7'b0, por_force_n_i}, {7'b0, exp[0]});
  endtask

  always @(posedge clk_master) begin
    if (reset_mon) begin
      {led_s, wp_s, scratch_s, por_s, geth_s} = '0;
      txn_open = 1'b0;
      rdy_seen = 1'b0;
    end else begin
      if (epb_rdy_i && !rdy_prev && cs_n_prev)
        report_fault("epb_rdy_o rose while chip select was high");
      if (!epb_rdy_i && rdy_prev && !cs_n_prev)
        report_fault("epb_rdy_o dropped while the host still held chip select");
      if (!txn_open && epb_rdy_i)
        report_fault("epb_rdy_o is high with no host cycle in progress");

      if (!txn_open && !epb_cs_n_i && !epb_rdy_i) begin
        txn_open = 1'b1;
        rdy_seen = 1'b0;
        t_we     = !epb_we_n_i;
        t_addr   = epb_addr_i;
        t_wdata  = epb_wdata_i;
      end else if (txn_open && epb_rdy_i && !rdy_seen) begin
        rdy_seen = 1'b1;
        if (t_we) apply_write(t_addr, t_wdata);
        else compare_value("epb_rdata_o", epb_rdata_i, expected_read(t_addr));
      end else if (txn_open && rdy_seen && !epb_rdy_i) begin
        txn_open = 1'b0;
      end

      // pins settle only once the access has completed
      if (!txn_open || rdy_seen) check_pins();
      if (!reset_por_n_i) begin
        por_s  = 1'b0;
        geth_s = 1'b0;
      end
    end
    rdy_prev  = epb_rdy_i;
    cs_n_prev = epb_cs_n_i;
  end

endmodule

// ==== verification/board_ctrl_tb.sv ====
`timescale 1ns/100ps

module board_ctrl_tb;

  import board_ctrl_pkg::*;

  localparam int NUM_TXN    = 200;
  localparam int MAX_CYCLES = 5000;  // 200 accesses of up to 20 cycles, plus reset

  logic       clk_master = 1'b0;
  logic       reset_mon;
  logic       epb_cs_n_i;
  logic       epb_we_n_i;
  epb_addr_t  epb_addr_i;
  bus_data_t  epb_wdata_i;
  bus_data_t  epb_rdata_o;
  logic       epb_rdy_o;
  bus_data_t  sys_config_i;
  logic [3:0] user_dip_i;
  logic [3:0] config_dip_i;
  logic       flash_busy_n_i;
  logic       ppc_syserr_i;
  logic [1:0] user_led_n_o;
  logic       eeprom_wp_o;
  logic       flash_wp_n_o;
  logic       reset_por_n_i;
  logic       reset_debug_n_i;
  logic       ppc_reset_n_o;
  logic       ppc_ddr2_reset_n_o;
  logic       geth_reset_n_o;
  logic       por_force_n_o;
  int         error_count;
  int         check_count;
  int         cycles = 0;

  always #4 clk_master = ~clk_master;

  board_ctrl_top UUT (.*);

  board_ctrl_checker u_checker (
    .clk_master, .reset_mon, .epb_cs_n_i, .epb_we_n_i, .epb_addr_i, .epb_wdata_i,
    .epb_rdata_i(epb_rdata_o), .epb_rdy_i(epb_rdy_o),
    .sys_config_i, .user_dip_i, .config_dip_i, .flash_busy_n_i, .ppc_syserr_i,
    .reset_por_n_i, .reset_debug_n_i,
    .user_led_n_i(user_led_n_o), .eeprom_wp_i(eeprom_wp_o), .flash_wp_n_i(flash_wp_n_o),
    .ppc_reset_n_i(ppc_reset_n_o), .ppc_ddr2_reset_n_i(ppc_ddr2_reset_n_o),
    .geth_reset_n_i(geth_reset_n_o), .por_force_n_i(por_force_n_o),
    .error_count_o(error_count), .check_count_o(check_count)
  );

  always @(posedge clk_master) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("TIMEOUT: the test did not finish within %0d cycles", MAX_CYCLES);
      $display("errors %0d, checks %0d", error_count, check_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // full four-phase host cycle, cs held hold_cycles extra cycles after ready
  task automatic epb_cycle(input logic we, input epb_addr_t addr, input bus_data_t wdata,
                           input int unsigned hold_cycles);
    epb_cs_n_i  <= 1'b0;
    epb_we_n_i  <= !we;
    epb_addr_i  <= addr;
    epb_wdata_i <= wdata;
    @(posedge clk_master);
    while (!epb_rdy_o) @(posedge clk_master);
    repeat (hold_cycles) @(posedge clk_master);
    epb_cs_n_i <= 1'b1;
    @(posedge clk_master);
    while (epb_rdy_o) @(posedge clk_master);  // wait for ready to drop before the next
  endtask

  task automatic shuffle_inputs();
    sys_config_i    <= 8'($urandom);
    user_dip_i      <= 4'($urandom);
    config_dip_i    <= 4'($urandom);
    flash_busy_n_i  <= 1'($urandom);
    ppc_syserr_i    <= 1'($urandom);
    reset_debug_n_i <= 1'($urandom);
  endtask

  task automatic pulse_por();
    reset_por_n_i <= 1'b0;
    repeat (2) @(posedge clk_master);
    reset_por_n_i <= 1'b1;
    @(posedge clk_master);
  endtask

  initial begin
    int unsigned seed_ret;
    epb_addr_t   addr;
    seed_ret        = $urandom(95918);
    reset_mon       = 1'b1;
    epb_cs_n_i      = 1'b1;
    epb_we_n_i      = 1'b1;
    epb_addr_i      = '0;
    epb_wdata_i     = '0;
    sys_config_i    = '0;
    user_dip_i      = '0;
    config_dip_i    = '0;
    flash_busy_n_i  = 1'b1;
    ppc_syserr_i    = 1'b0;
    reset_por_n_i   = 1'b1;
    reset_debug_n_i = 1'b1;
    repeat (10) @(posedge clk_master);
    reset_mon <= 1'b0;
    repeat (2) @(posedge clk_master);
    for (int i = 0; i < NUM_TXN; i++) begin
      if (i % 25 == 24) pulse_por();  // clears the sticky por_force bit
      shuffle_inputs();
      addr = 5'($urandom);
      if (addr[4:3] == SLAVE_RESET && $urandom_range(1, 0) == 1) addr[2:0] = RST_CONTROL;
      epb_cycle(1'($urandom), addr, 8'($urandom), $urandom_range(3, 0));
    end
    repeat (5) @(posedge clk_master);
    $display("errors %0d, checks %0d", error_count, check_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/board_ctrl_pkg.sv
logic/epb_bridge.sv
logic/bus_decode.sv
logic/misc_regs.sv
logic/reset_ctrl.sv
logic/bus_return.sv
logic/board_ctrl_top.sv
verification/board_ctrl_checker.sv
verification/board_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the board controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module board_ctrl_tb -Mdir obj_dir
./obj_dir/Vboard_ctrl_tb | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
